// ==== filelist.f ====
+incdir+testbench
src/modexp_pkg.sv
src/mont_bus_if.sv
src/mul_add_unit.sv
src/operand_store.sv
src/mont_product.sv
src/exp_controller.sv
src/modexp_top.sv
testbench/tb_modexp.sv

// ==== src/exp_controller.sv ====
// ====================================================================
// load handshake, square-and-multiply schedule, result handshake
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module exp_controller #(
	parameter int num_words = 32
) (
	input logic clk,
	input logic reset,
	input logic word_req,
	output logic word_ack,
	output logic res_req,
	input logic res_ack,
	output logic busy,
	output logic load_en,
	output logic [$clog2(num_words)-1:0] load_idx,
	output logic c_init,
	output logic [$clog2(num_words*modexp_pkg::word_width)-1:0] e_bit_idx,
	input logic e_bit,
	output logic [$clog2(num_words)-1:0] res_idx,
	output logic start,
	input logic done,
	output modexp_pkg::op_sel_t op_sel
);

	localparam int iw = $clog2(num_words);
	localparam int bw = $clog2(num_words*modexp_pkg::word_width);
	localparam logic [iw-1:0] last_idx = iw'(num_words - 1);
	localparam logic [bw-1:0] top_bit = bw'(num_words*modexp_pkg::word_width - 1);

	modexp_pkg::exp_state_t state;
	logic [bw-1:0] bit_idx; // current exponent bit
	logic res_wait; // waiting for res_ack to fall
	logic last_bit;

	assign last_bit = (bit_idx == '0);
	assign e_bit_idx = bit_idx;
	assign load_en = (state == modexp_pkg::es_load) && word_req && !word_ack;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= modexp_pkg::es_idle;
			word_ack <= 1'b0;
			res_req <= 1'b0;
			busy <= 1'b0;
			start <= 1'b0;
			c_init <= 1'b0;
			op_sel <= modexp_pkg::sel_to_mont;
			load_idx <= '0;
			res_idx <= '0;
			bit_idx <= '0;
			res_wait <= 1'b0;
		end else begin
			start <= 1'b0; // one cycle pulses
			c_init <= 1'b0;
			case (state)
				modexp_pkg::es_idle: begin
					if (word_req) begin // first request starts a run
						state <= modexp_pkg::es_load;
						load_idx <= '0;
					end
				end
				modexp_pkg::es_load: begin
					if (load_en) begin // word captured this edge
						word_ack <= 1'b1;
						busy <= 1'b1;
					end else if (word_ack && !word_req) begin
						word_ack <= 1'b0;
						load_idx <= load_idx + 1'b1;
						if (load_idx == last_idx) begin
							state <= modexp_pkg::es_to_mont;
							op_sel <= modexp_pkg::sel_to_mont;
							start <= 1'b1;
							c_init <= 1'b1; // c_bar = r
							bit_idx <= top_bit;
						end
					end
				end
				modexp_pkg::es_to_mont: begin
					if (done)
						state <= modexp_pkg::es_find_one;
				end
				modexp_pkg::es_find_one: begin // one bit per cycle from the top
					if (e_bit) begin
						state <= modexp_pkg::es_square;
						op_sel <= modexp_pkg::sel_square;
						start <= 1'b1;
					end else if (last_bit) begin // e is zero
						state <= modexp_pkg::es_from_mont;
						op_sel <= modexp_pkg::sel_from_mont;
						start <= 1'b1;
					end else begin
						bit_idx <= bit_idx - 1'b1;
					end
				end
				modexp_pkg::es_square, modexp_pkg::es_multiply: begin
					if (done) begin
						start <= 1'b1; // every branch launches a product
						if (state == modexp_pkg::es_square && e_bit) begin
							state <= modexp_pkg::es_multiply;
							op_sel <= modexp_pkg::sel_multiply;
						end else if (last_bit) begin
							state <= modexp_pkg::es_from_mont;
							op_sel <= modexp_pkg::sel_from_mont;
						end else begin
							bit_idx <= bit_idx - 1'b1;
							state <= modexp_pkg::es_square;
							op_sel <= modexp_pkg::sel_square;
						end
					end
				end
				modexp_pkg::es_from_mont: begin
					if (done) begin
						state <= modexp_pkg::es_output;
						res_idx <= '0;
					end
				end
				default: begin // output
					if (!res_req && !res_wait) begin
						res_req <= 1'b1; // store loads res_word on this same edge
					end else if (res_req && res_ack) begin
						res_req <= 1'b0;
						res_wait <= 1'b1;
					end else if (res_wait && !res_ack) begin
						res_wait <= 1'b0;
						res_idx <= res_idx + 1'b1;
						if (res_idx == last_idx) begin
							state <= modexp_pkg::es_idle;
							busy <= 1'b0;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/modexp_pkg.sv ====
// ====================================================================
// shared word types, product select and state encodings
// ====================================================================
`default_nettype none

package modexp_pkg;

	localparam int word_width = 32; // multiply-add unit is built for this

	typedef logic [word_width-1:0] word_t; // one operand word
	typedef logic [2*word_width-1:0] dword_t; // {carry, sum} of a multiply-add

	// which montgomery product is wanted
	typedef enum logic [1:0] {
		sel_to_mont, // m * t
		sel_square, // c_bar * c_bar
		sel_multiply, // c_bar * m_bar
		sel_from_mont // 1 * c_bar
	} op_sel_t;

	typedef enum logic [2:0] {
		es_idle,
		es_load, // word load handshake
		es_to_mont,
		es_find_one, // leading one of e
		es_square,
		es_multiply,
		es_from_mont,
		es_output // result handshake
	} exp_state_t;

	// cios steps
	typedef enum logic [2:0] {
		ms_idle,
		ms_mul_row, // v += x[i] * y
		ms_fold_top, // fold carry into v[s], v[s+1]
		ms_get_q, // q = v[0] * n0'
		ms_reduce_row, // v = (v + q * n) >> w
		ms_shift_top, // v[s-1] = v[s] + c
		ms_carry_top, // v[s] = v[s+1] + c
		ms_finish
	} mont_state_t;

endpackage

`default_nettype wire

// ==== src/modexp_top.sv ====
// ====================================================================
// modular exponentiation engine top, plain host ports
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module modexp_top #(
	parameter int num_words = 32
) (
	input logic clk,
	input logic reset,
	input logic word_req,
	output logic word_ack,
	input modexp_pkg::word_t m_word,
	input modexp_pkg::word_t e_word,
	input modexp_pkg::word_t n_word,
	input modexp_pkg::word_t r_word,
	input modexp_pkg::word_t t_word,
	input modexp_pkg::word_t n0_prime,
	output logic res_req,
	input logic res_ack,
	output modexp_pkg::word_t res_word,
	output logic busy
);

	localparam int iw = $clog2(num_words);
	localparam int bw = $clog2(num_words*modexp_pkg::word_width);

	logic load_en;
	logic [iw-1:0] load_idx;
	logic c_init;
	logic [bw-1:0] e_bit_idx;
	logic e_bit;
	logic [iw-1:0] res_idx;
	logic start; // controller to sequencer
	logic done;

	mont_bus_if #(.num_words(num_words)) mbus ();

	operand_store #(.num_words(num_words)) u_store (
		.clk(clk),
		.reset(reset),
		.bus(mbus.store),
		.load_en(load_en),
		.load_idx(load_idx),
		.m_word(m_word),
		.e_word(e_word),
		.n_word(n_word),
		.r_word(r_word),
		.t_word(t_word),
		.n0_prime_in(n0_prime),
		.c_init(c_init),
		.e_bit_idx(e_bit_idx),
		.e_bit(e_bit),
		.res_idx(res_idx),
		.res_word(res_word)
	);

	mont_product #(.num_words(num_words)) u_mont (
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.bus(mbus.mont_product)
	);

	exp_controller #(.num_words(num_words)) u_ctrl (
		.clk(clk),
		.reset(reset),
		.word_req(word_req),
		.word_ack(word_ack),
		.res_req(res_req),
		.res_ack(res_ack),
		.busy(busy),
		.load_en(load_en),
		.load_idx(load_idx),
		.c_init(c_init),
		.e_bit_idx(e_bit_idx),
		.e_bit(e_bit),
		.res_idx(res_idx),
		.start(start),
		.done(done),
		.op_sel(mbus.op_sel) // picks operands and write bank
	);

endmodule

`default_nettype wire

// ==== src/mont_bus_if.sv ====
// ====================================================================
// operand read and result write bus, sequencer to operand store
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

interface mont_bus_if #(
	parameter int num_words = 32
);

	localparam int idx_w = $clog2(num_words);

	logic [idx_w-1:0] x_idx; // outer loop word of x
	logic [idx_w-1:0] y_idx; // inner loop word of y and n
	logic wr_en;
	logic [idx_w-1:0] wr_idx;
	modexp_pkg::word_t wr_word; // finished result word
	modexp_pkg::word_t x_word;
	modexp_pkg::word_t y_word;
	modexp_pkg::word_t n_word;
	modexp_pkg::word_t n0_prime;
	modexp_pkg::op_sel_t op_sel; // held by the controller for a whole product

	modport mont_product (
		output x_idx, y_idx, wr_en, wr_idx, wr_word,
		input x_word, y_word, n_word, n0_prime
	);

	modport store (
		input x_idx, y_idx, wr_en, wr_idx, wr_word, op_sel,
		output x_word, y_word, n_word, n0_prime
	);

endinterface

`default_nettype wire

// ==== src/mont_product.sv ====
// ====================================================================
// cios montgomery product sequencer around one multiply-add unit
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mont_product #(
	parameter int num_words = 32
) (
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	mont_bus_if.mont_product bus
);

	localparam int iw = $clog2(num_words);
	localparam logic [iw-1:0] last_idx = iw'(num_words - 1);

	modexp_pkg::mont_state_t state;
	logic phase; // 0 issue, 1 capture
	logic [iw-1:0] i; // outer word index
	logic [iw-1:0] j; // inner word index
	modexp_pkg::word_t v [num_words+2]; // accumulator, two extra top words
	modexp_pkg::word_t carry;
	modexp_pkg::word_t q; // reduction multiplier of this row
	modexp_pkg::word_t ma_x;
	modexp_pkg::word_t ma_y;
	modexp_pkg::word_t ma_z;
	modexp_pkg::word_t ma_cin;
	modexp_pkg::word_t ma_s;
	modexp_pkg::word_t ma_cout;
	logic last_row;

	mul_add_unit u_mul_add (
		.clk(clk),
		.reset(reset),
		.x(ma_x),
		.y(ma_y),
		.z(ma_z),
		.cin(ma_cin),
		.s(ma_s),
		.cout(ma_cout)
	);

	// operand select per step
	always_comb begin
		ma_x = '0;
		ma_y = '0;
		ma_z = '0;
		ma_cin = carry;
		unique case (state)
			modexp_pkg::ms_mul_row: begin
				ma_x = bus.x_word;
				ma_y = bus.y_word;
				ma_z = v[j];
				ma_cin = (j == '0) ? '0 : carry; // row starts with no carry
			end
			modexp_pkg::ms_fold_top: ma_z = v[num_words];
			modexp_pkg::ms_get_q: begin
				ma_x = v[0];
				ma_y = bus.n0_prime;
				ma_cin = '0;
			end
			modexp_pkg::ms_reduce_row: begin
				ma_x = q;
				ma_y = bus.n_word;
				ma_z = v[j];
				ma_cin = (j == '0) ? '0 : carry;
			end
			modexp_pkg::ms_shift_top: ma_z = v[num_words];
			modexp_pkg::ms_carry_top: ma_z = v[num_words+1];
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= modexp_pkg::ms_idle;
			phase <= 1'b0;
			i <= '0;
			j <= '0;
			carry <= '0;
			for (int k = 0; k < num_words + 2; k++)
				v[k] <= '0;
		end else begin
			case (state)
				modexp_pkg::ms_idle: begin
					if (start) begin
						state <= modexp_pkg::ms_mul_row;
						i <= '0;
						j <= '0;
					end
				end
				modexp_pkg::ms_finish: begin // leave v clean for the next product
					carry <= '0;
					for (int k = 0; k < num_words + 2; k++)
						v[k] <= '0;
					state <= modexp_pkg::ms_idle;
				end
				default: begin
					phase <= ~phase;
					if (phase) begin // multiply-add result is valid now
						unique case (state)
							modexp_pkg::ms_mul_row: begin
								v[j] <= ma_s;
								carry <= ma_cout;
								j <= (j == last_idx) ? '0 : j + 1'b1;
								if (j == last_idx)
									state <= modexp_pkg::ms_fold_top;
							end
							modexp_pkg::ms_fold_top: begin
								v[num_words] <= ma_s;
								v[num_words+1] <= ma_cout;
								state <= modexp_pkg::ms_get_q;
							end
							modexp_pkg::ms_get_q: state <= modexp_pkg::ms_reduce_row;
							modexp_pkg::ms_reduce_row: begin
								if (j != '0)
									v[j-1'b1] <= ma_s; // shift down one word
								carry <= ma_cout;
								j <= (j == last_idx) ? '0 : j + 1'b1;
								if (j == last_idx)
									state <= modexp_pkg::ms_shift_top;
							end
							modexp_pkg::ms_shift_top: begin
								v[num_words-1] <= ma_s;
								carry <= ma_cout;
								state <= modexp_pkg::ms_carry_top;
							end
							default: begin // carry_top
								v[num_words] <= ma_s;
								i <= i + 1'b1;
								state <= last_row ? modexp_pkg::ms_finish
									: modexp_pkg::ms_mul_row;
							end
						endcase
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == modexp_pkg::ms_get_q && phase)
			q <= ma_s; // low word only, mod 2^32
	end

	assign last_row = (i == last_idx);
	assign bus.x_idx = i;
	assign bus.y_idx = j;

	// words of the last row are final as they shift down, so they go out to the store here
	assign bus.wr_en = last_row && phase
		&& ((state == modexp_pkg::ms_reduce_row && j != '0)
		|| state == modexp_pkg::ms_shift_top);
	assign bus.wr_idx = (state == modexp_pkg::ms_shift_top) ? last_idx : j - 1'b1;
	assign bus.wr_word = ma_s;
	assign done = (state == modexp_pkg::ms_finish); // last word already written

endmodule

`default_nettype wire

// ==== src/mul_add_unit.sv ====
// ====================================================================
// registered multiply-add, s/cout = x*y + z + cin
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module mul_add_unit (
	input logic clk,
	input logic reset,
	input modexp_pkg::word_t x,
	input modexp_pkg::word_t y,
	input modexp_pkg::word_t z,
	input modexp_pkg::word_t cin,
	output modexp_pkg::word_t s,
	output modexp_pkg::word_t cout
);

	localparam int ww = modexp_pkg::word_width;

	modexp_pkg::dword_t acc; // full 64 bit result, never overflows

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= x * y + z + cin; // operands widen to 64 bits here
		end
	end

	assign s = acc[ww-1:0]; // low word
	assign cout = acc[2*ww-1:ww]; // high word, next carry

endmodule

`default_nettype wire

// ==== src/operand_store.sv ====
// ====================================================================
// word banks for m, e, n, r, t, m_bar, c_bar and operand muxing
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module operand_store #(
	parameter int num_words = 32
) (
	input logic clk,
	input logic reset,
	mont_bus_if.store bus,
	input logic load_en,
	input logic [$clog2(num_words)-1:0] load_idx,
	input modexp_pkg::word_t m_word,
	input modexp_pkg::word_t e_word,
	input modexp_pkg::word_t n_word,
	input modexp_pkg::word_t r_word,
	input modexp_pkg::word_t t_word,
	input modexp_pkg::word_t n0_prime_in,
	input logic c_init,
	input logic [$clog2(num_words*modexp_pkg::word_width)-1:0] e_bit_idx,
	output logic e_bit,
	input logic [$clog2(num_words)-1:0] res_idx,
	output modexp_pkg::word_t res_word
);

	localparam int wb = $clog2(modexp_pkg::word_width); // bit select width
	localparam int bw = $clog2(num_words*modexp_pkg::word_width);

	modexp_pkg::word_t m_bank [num_words];
	modexp_pkg::word_t e_bank [num_words];
	modexp_pkg::word_t n_bank [num_words];
	modexp_pkg::word_t r_bank [num_words]; // R mod n
	modexp_pkg::word_t t_bank [num_words]; // R^2 mod n
	modexp_pkg::word_t mbar_bank [num_words];
	modexp_pkg::word_t cbar_bank [num_words];
	modexp_pkg::word_t n0_q;
	logic cbar_valid; // c_bar holds defined data

	always_ff @(posedge clk) begin
		if (load_en) begin
			m_bank[load_idx] <= m_word;
			e_bank[load_idx] <= e_word;
			n_bank[load_idx] <= n_word;
			r_bank[load_idx] <= r_word;
			t_bank[load_idx] <= t_word;
		end
		if (bus.wr_en) begin
			if (bus.op_sel == modexp_pkg::sel_to_mont)
				mbar_bank[bus.wr_idx] <= bus.wr_word; // m_bar = MonPro(m, t)
			else
				cbar_bank[bus.wr_idx] <= bus.wr_word;
		end
		if (c_init) begin
			for (int k = 0; k < num_words; k++)
				cbar_bank[k] <= r_bank[k]; // c_bar starts at r
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			n0_q <= '0;
			cbar_valid <= 1'b0;
			res_word <= '0;
		end else begin
			if (load_en && load_idx == '0)
				n0_q <= n0_prime_in; // taken with the first word
			if (c_init)
				cbar_valid <= 1'b1;
			if (cbar_valid)
				res_word <= cbar_bank[res_idx]; // one cycle behind res_idx
		end
	end

	always_comb begin
		unique case (bus.op_sel)
			modexp_pkg::sel_to_mont: begin
				bus.x_word = m_bank[bus.x_idx];
				bus.y_word = t_bank[bus.y_idx];
			end
			modexp_pkg::sel_square: begin
				bus.x_word = cbar_bank[bus.x_idx];
				bus.y_word = cbar_bank[bus.y_idx];
			end
			modexp_pkg::sel_multiply: begin
				bus.x_word = cbar_bank[bus.x_idx];
				bus.y_word = mbar_bank[bus.y_idx];
			end
			default: begin // from_mont, x is the number one
				bus.x_word = (bus.x_idx == '0) ? modexp_pkg::word_t'(1) : '0;
				bus.y_word = cbar_bank[bus.y_idx];
			end
		endcase
	end

	assign bus.n_word = n_bank[bus.y_idx];
	assign bus.n0_prime = n0_q;
	assign e_bit = e_bank[e_bit_idx[bw-1:wb]][e_bit_idx[wb-1:0]];

endmodule

`default_nettype wire

// ==== testbench/tb_ref_model.svh ====
// ======================================================================
// reference arithmetic: wide modexp and the montgomery constants r, t, n0'
// ======================================================================
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// a*b mod n on double width vectors
function automatic logic [op_bits-1:0] mul_mod(input logic [op_bits-1:0] a,
		input logic [op_bits-1:0] b, input logic [op_bits-1:0] n);
	logic [2*op_bits-1:0] p;
	p = {{op_bits{1'b0}}, a} * {{op_bits{1'b0}}, b};
	return op_bits'(p % {{op_bits{1'b0}}, n});
endfunction

// right to left binary method, independent of the engine schedule
function automatic logic [op_bits-1:0] mod_exp(input logic [op_bits-1:0] m,
		input logic [op_bits-1:0] e, input logic [op_bits-1:0] n);
	logic [op_bits-1:0] acc;
	logic [op_bits-1:0] base;
	acc = op_bits'(1) % n;
	base = m % n;
	for (int k = 0; k < op_bits; k++) begin
		if (e[k])
			acc = mul_mod(acc, base, n);
		base = mul_mod(base, base, n); // next power of two
	end
	return acc;
endfunction

function automatic logic [op_bits-1:0] mont_r_of(input logic [op_bits-1:0] n);
	logic [op_bits:0] big_r;
	big_r = '0;
	big_r[op_bits] = 1'b1; // R = 2^op_bits
	return op_bits'(big_r % {1'b0, n});
endfunction

function automatic logic [op_bits-1:0] mont_t_of(input logic [op_bits-1:0] n);
	logic [2*op_bits:0] big_r2;
	big_r2 = '0;
	big_r2[2*op_bits] = 1'b1; // R^2
	return op_bits'(big_r2 % {{(op_bits+1){1'b0}}, n});
endfunction

// newton steps double the correct low bits, 1 -> 32 in five steps
function automatic logic [31:0] n0_prime_of(input logic [31:0] n0);
	logic [31:0] x;
	x = 32'd1;
	repeat (5)
		x = x * (32'd2 - n0 * x);
	return -x;
endfunction

`endif

// ==== testbench/tb_modexp.sv ====
// ======================================================================
// testbench for modexp_top with clock, host handshakes, tests, monitor and report
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_modexp;

	localparam int num_words = 4;
	localparam int op_bits = num_words * 32;
	localparam int prod_cycles = num_words * (4 * num_words + 8) + 2; // one product
	localparam int max_delay = 5; // slow host delay bound
	localparam int num_runs = 9;
	localparam int hs_cycles = 2 * num_words * (2 * max_delay + 8) + op_bits;
	localparam int run_cycles = (2 * op_bits + 2) * (prod_cycles + 2) + hs_cycles;
	localparam int timeout_cycles = num_runs * run_cycles + 20;

	logic clk;
	logic reset;
	logic word_req;
	logic word_ack;
	modexp_pkg::word_t m_word;
	modexp_pkg::word_t e_word;
	modexp_pkg::word_t n_word;
	modexp_pkg::word_t r_word;
	modexp_pkg::word_t t_word;
	modexp_pkg::word_t n0_prime;
	logic res_req;
	logic res_ack;
	modexp_pkg::word_t res_word;
	logic busy;
	int errors;
	int tests_run;
	int tests_failed;
	int delay_max; // 0 for a fast host
	int cycle_count;
	logic ack_q; // monitor history
	logic req_q; // word_req as sampled at the last edge
	logic res_req_q;
	logic res_ack_q;
	logic busy_expected;
	int res_done; // finished result handshakes this run
	modexp_pkg::word_t held_word;

	`include "tb_ref_model.svh"

	modexp_top #(.num_words(num_words)) DUT (
		.clk(clk),
		.reset(reset),
		.word_req(word_req),
		.word_ack(word_ack),
		.m_word(m_word),
		.e_word(e_word),
		.n_word(n_word),
		.r_word(r_word),
		.t_word(t_word),
		.n0_prime(n0_prime),
		.res_req(res_req),
		.res_ack(res_ack),
		.res_word(res_word),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped: no result after %0d clock cycles", timeout_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	// protocol monitor sampling mid cycle where every signal has settled
	always @(negedge clk) begin
		if (reset) begin
			ack_q = 1'b0;
			req_q = 1'b0;
			res_req_q = 1'b0;
			res_ack_q = 1'b0;
			busy_expected = 1'b0;
			res_done = 0;
		end else begin
			if (word_ack && !ack_q) begin
				assert (req_q) else begin // host may already have dropped req
					$display("word_ack rose while word_req was low at %0t", $time);
					errors++;
				end
				busy_expected = 1'b1; // run begins at first ack
			end
			assert (busy == busy_expected) else begin
				$display("[ERROR] %0t busy is %b, expected %b", $time, busy, busy_expected);
				errors++;
			end
			if (res_req && res_req_q)
				assert (res_word == held_word) else begin
					$display("res_word changed while res_req was high at %0t", $time);
					errors++;
				end
			if (!res_ack && res_ack_q) begin // one result handshake done
				res_done++;
				if (res_done == num_words) begin
					busy_expected = 1'b0; // busy drops on the next edge
					res_done = 0;
				end
			end
			ack_q = word_ack;
			req_q = word_req;
			res_req_q = res_req;
			res_ack_q = res_ack;
			held_word = res_word;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1; // drive just after the edge
	endtask

	function automatic int pick_delay();
		return (delay_max == 0) ? 0 : int'($urandom_range(delay_max, 0));
	endfunction

	function automatic logic [op_bits-1:0] random_wide();
		logic [op_bits-1:0] v;
		for (int w = 0; w < num_words; w++)
			v[w*32 +: 32] = $urandom();
		return v;
	endfunction

	function automatic logic [op_bits-1:0] random_modulus();
		logic [op_bits-1:0] v;
		v = random_wide();
		v[op_bits-1 -: 2] = 2'b00; // 4n < R
		v[0] = 1'b1; // odd
		return v;
	endfunction

	task automatic load_operands(input logic [op_bits-1:0] m, input logic [op_bits-1:0] e,
			input logic [op_bits-1:0] n);
		logic [op_bits-1:0] r;
		logic [op_bits-1:0] t;
		r = mont_r_of(n);
		t = mont_t_of(n);
		for (int w = 0; w < num_words; w++) begin // lowest word first
			m_word = m[w*32 +: 32];
			e_word = e[w*32 +: 32];
			n_word = n[w*32 +: 32];
			r_word = r[w*32 +: 32];
			t_word = t[w*32 +: 32];
			n0_prime = n0_prime_of(n[31:0]);
			word_req = 1'b1;
			while (!word_ack)
				next_cycle();
			repeat (pick_delay())
				next_cycle(); // host holds req a while
			word_req = 1'b0;
			while (word_ack)
				next_cycle();
		end
	endtask

	task automatic collect_result(input logic [op_bits-1:0] expected, output int bad);
		modexp_pkg::word_t want;
		bad = 0;
		for (int w = 0; w < num_words; w++) begin
			while (!res_req)
				next_cycle();
			want = expected[w*32 +: 32];
			assert (res_word == want) else begin
				$display("[ERROR] %0t result word %0d is %h, expected %h",
					$time, w, res_word, want);
				bad++;
			end
			repeat (pick_delay())
				next_cycle(); // late ack
			res_ack = 1'b1;
			while (res_req)
				next_cycle();
			repeat (pick_delay())
				next_cycle();
			res_ack = 1'b0;
		end
	endtask

	task automatic run_test(input string name, input logic [op_bits-1:0] m,
			input logic [op_bits-1:0] e, input logic [op_bits-1:0] n);
		logic [op_bits-1:0] expected;
		int bad;
		expected = mod_exp(m, e, n);
		load_operands(m, e, n);
		collect_result(expected, bad);
		tests_run++;
		errors += bad;
		if (bad != 0)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (bad == 0) ? "ok" : "wrong result");
	endtask

	initial begin
		logic [op_bits-1:0] n;
		logic [op_bits-1:0] m;
		void'($urandom(32'h781d3a5a));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		delay_max = 0;
		reset = 1'b1;
		word_req = 1'b0;
		m_word = '0;
		e_word = '0;
		n_word = '0;
		r_word = '0;
		t_word = '0;
		n0_prime = '0;
		res_ack = 1'b0;
		repeat (4)
			@(posedge clk);
		#1;
		reset = 1'b0;
		assert (!word_ack && !res_req && !busy) else begin
			$display("[ERROR] %0t word_ack, res_req or busy not low after reset", $time);
			errors++;
		end
		for (int k = 0; k < 3; k++) begin // back to back runs
			n = random_modulus();
			m = random_wide() % n;
			run_test("random operands", m, random_wide(), n);
		end
		n = random_modulus();
		m = random_wide() % n;
		run_test("exponent one", m, op_bits'(1), n);
		run_test("exponent zero", m, '0, n);
		run_test("top bit only", m, {1'b1, {(op_bits-1){1'b0}}}, n); // squares only
		run_test("all bits set", m, '1, n);
		delay_max = max_delay;
		for (int k = 0; k < 2; k++) begin
			n = random_modulus();
			m = random_wide() % n;
			run_test("slow host", m, random_wide(), n);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
